// File: Makefile
VERILATOR ?= verilator
TOP       ?= snes_load_tb
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SRCS    := $(shell grep -v '^+' $(FLIST)) include/snes_load_tb_tasks.svh

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/core_reset_gen.sv
module core_reset_gen
  import snes_load_pkg::*;
(
  input  logic clk_sys,
  input  logic reset,
  input  logic core_reset,
  input  logic load_busy,
  input  logic clearing,
  output logic core_reset_n,
  output logic refresh
);

  // four phases, same rate as the fill divider
  localparam int PHASE_W = $clog2(CLEAR_DIV_STEPS);

  // core reset only moves in this phase
  localparam logic [PHASE_W-1:0] RESET_PHASE = PHASE_W'(2);

  logic [PHASE_W-1:0] phase;

  // anything that must keep the core stopped
  logic hold_core;

  assign hold_core = core_reset | load_busy | clearing;

  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      phase        <= '0;
      refresh      <= 1'b0;
      core_reset_n <= 1'b0;
    end else begin
      phase <= phase + 1'b1;
      // one refresh slot per turn
      refresh <= (phase == '0);
      if (phase == RESET_PHASE) begin
        core_reset_n <= ~hold_core;
      end
    end
  end

endmodule

// File: design/load_sequencer.sv
module load_sequencer
  import snes_load_pkg::*;
(
  input  logic       clk_sys,
  input  logic       reset,
  input  logic       cart_download,
  input  mem_size_t  rom_size,
  input  mem_size_t  ram_size,
  output logic       clear_start,
  output logic       load_busy,
  output addr_mask_t rom_mask,
  output addr_mask_t ram_mask,
  output mem_size_t  sram_size
);

  // wide enough to hold the full parser delay
  localparam int CNT_W = $clog2(PARSER_DELAY + 1);

  // download strobe from the previous cycle
  logic             dl_q;
  logic [CNT_W-1:0] parser_cnt;

  // 1 KiB shifted by the size code, minus one
  function automatic addr_mask_t size_mask(mem_size_t code);
    size_mask = (MASK_BASE << code) - addr_mask_t'(1);
  endfunction

  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      dl_q        <= 1'b0;
      clear_start <= 1'b0;
      parser_cnt  <= '0;
      rom_mask    <= '0;
      ram_mask    <= '0;
      sram_size   <= '0;
    end else begin
      dl_q <= cart_download;
      // single pulse on the start of a download
      clear_start <= cart_download & ~dl_q;

      // end of download, give the header parser time to settle
      if (dl_q && !cart_download) begin
        parser_cnt <= CNT_W'(PARSER_DELAY);
      end else if (parser_cnt != '0) begin
        parser_cnt <= parser_cnt - 1'b1;
      end

      // masks in place before the core leaves reset
      if (parser_cnt == CNT_W'(1)) begin
        rom_mask <= size_mask(rom_size);
        // no save RAM for code 0
        ram_mask  <= (ram_size != '0) ? size_mask(ram_size) : '0;
        sram_size <= ram_size;
      end
    end
  end

  // hold the core while loading or parsing
  assign load_busy = cart_download | (parser_cnt != '0);

endmodule

// File: design/ram_clear_engine.sv
module ram_clear_engine
  import snes_load_pkg::*;
#(
  parameter int RAM_ADDR_BITS = ADDR_MAX_BITS
) (
  input  logic          clk_sys,
  input  logic          reset,
  input  logic          clear_start,
  input  fill_pattern_e wram_pattern,
  input  fill_pattern_e aram_pattern,
  output fill_req_t     fill,
  output logic          clearing
);

  localparam int DIV_W = $clog2(CLEAR_DIV_STEPS);

  // free running, so the first step lands on any phase
  logic [DIV_W-1:0]         clear_div;
  logic [RAM_ADDR_BITS-1:0] fill_addr;

  // pattern byte for one address
  function automatic ram_byte_t pattern_byte(fill_pattern_e pat,
                                             logic [RAM_ADDR_BITS-1:0] a);
    ram_byte_t b;
    case (pat)
      PAT_CHECKER: b = (a[8] ^ a[2]) ? 8'h66 : 8'h99;
      PAT_STRIPE:  b = (a[9] ^ a[0]) ? 8'hFF : 8'h00;
      PAT_55:      b = 8'h55;
      default:     b = 8'hFF;
    endcase
    return b;
  endfunction

  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      clear_div <= '0;
      clearing  <= 1'b0;
      fill_addr <= '0;
    end else begin
      clear_div <= clear_div + 1'b1;

      // start wins, otherwise stop after the last address
      if (clear_start) begin
        clearing <= 1'b1;
      end else if (&fill_addr) begin
        clearing <= 1'b0;
      end

      // one address per divider wrap
      if (clearing) begin
        if (clear_div == '0) begin
          fill_addr <= fill_addr + 1'b1;
        end
      end else begin
        fill_addr <= '0;
      end
    end
  end

  always_comb begin
    fill.active    = clearing;
    fill.addr      = ADDR_MAX_BITS'(fill_addr);
    fill.wram_byte = pattern_byte(wram_pattern, fill_addr);
    fill.aram_byte = pattern_byte(aram_pattern, fill_addr);
  end

endmodule

// File: design/snes_load_pkg.sv
package snes_load_pkg;

  // size code from the cartridge header
  typedef logic [3:0] mem_size_t;

  // address mask handed to the core
  typedef logic [23:0] addr_mask_t;

  // one byte of work or audio RAM
  typedef logic [7:0] ram_byte_t;

  // fill pattern written during the RAM clear
  typedef enum logic [1:0] {
    PAT_CHECKER = 2'd0,
    PAT_STRIPE  = 2'd1,
    PAT_55      = 2'd2,
    PAT_FF      = 2'd3
  } fill_pattern_e;

  // widest RAM address, sets the struct address fields
  localparam int ADDR_MAX_BITS = 17;

  // size code 0 means 1 KiB
  localparam addr_mask_t MASK_BASE = 24'd1024;

  // header parser settle time after the download ends
  localparam int PARSER_DELAY = 6;

  // clocks spent on each fill address
  localparam int CLEAR_DIV_STEPS = 4;

  // fill write shared by both RAMs
  typedef struct packed {
    logic                     active;
    logic [ADDR_MAX_BITS-1:0] addr;
    ram_byte_t                wram_byte;
    ram_byte_t                aram_byte;
  } fill_req_t;

  // core side access to one RAM
  typedef struct packed {
    logic [ADDR_MAX_BITS-1:0] addr;
    ram_byte_t                wdata;
    logic                     we;
    logic                     re;
  } ram_req_t;

endpackage

// File: design/snes_load_top.sv
module snes_load_top
  import snes_load_pkg::*;
#(
  parameter int RAM_ADDR_BITS = ADDR_MAX_BITS
) (
  input  logic          clk_sys,
  input  logic          reset,
  input  logic          core_reset,
  input  logic          cart_download,
  input  mem_size_t     rom_size,
  input  mem_size_t     ram_size,
  input  fill_pattern_e wram_pattern,
  input  fill_pattern_e aram_pattern,
  input  ram_req_t      wram_req,
  input  ram_req_t      aram_req,
  output ram_byte_t     wram_rdata,
  output ram_byte_t     aram_rdata,
  output addr_mask_t    rom_mask,
  output addr_mask_t    ram_mask,
  output mem_size_t     sram_size,
  output logic          clear_busy,
  output logic          core_reset_n,
  output logic          refresh
);

  // sequencer to clear engine and reset generator
  logic clear_start;
  logic load_busy;

  // shared fill write to both RAMs
  fill_req_t fill;

  load_sequencer u_load_sequencer (
    .clk_sys       (clk_sys),
    .reset         (reset),
    .cart_download (cart_download),
    .rom_size      (rom_size),
    .ram_size      (ram_size),
    .clear_start   (clear_start),
    .load_busy     (load_busy),
    .rom_mask      (rom_mask),
    .ram_mask      (ram_mask),
    .sram_size     (sram_size)
  );

  ram_clear_engine #(
    .RAM_ADDR_BITS (RAM_ADDR_BITS)
  ) u_ram_clear_engine (
    .clk_sys      (clk_sys),
    .reset        (reset),
    .clear_start  (clear_start),
    .wram_pattern (wram_pattern),
    .aram_pattern (aram_pattern),
    .fill         (fill),
    .clearing     (clear_busy)
  );

  // work RAM takes the wram fill byte
  work_ram #(
    .RAM_ADDR_BITS (RAM_ADDR_BITS)
  ) wram (
    .clk_sys       (clk_sys),
    .fill          (fill),
    .use_aram_byte (1'b0),
    .core_req      (wram_req),
    .rdata         (wram_rdata)
  );

  // audio RAM takes its own pattern
  work_ram #(
    .RAM_ADDR_BITS (RAM_ADDR_BITS)
  ) aram (
    .clk_sys       (clk_sys),
    .fill          (fill),
    .use_aram_byte (1'b1),
    .core_req      (aram_req),
    .rdata         (aram_rdata)
  );

  core_reset_gen u_core_reset_gen (
    .clk_sys      (clk_sys),
    .reset        (reset),
    .core_reset   (core_reset),
    .load_busy    (load_busy),
    .clearing     (clear_busy),
    .core_reset_n (core_reset_n),
    .refresh      (refresh)
  );

endmodule

// File: design/work_ram.sv
module work_ram
  import snes_load_pkg::*;
#(
  parameter int RAM_ADDR_BITS = ADDR_MAX_BITS
) (
  input  logic      clk_sys,
  input  fill_req_t fill,
  input  logic      use_aram_byte,
  input  ram_req_t  core_req,
  output ram_byte_t rdata
);

  localparam int DEPTH = 2 ** RAM_ADDR_BITS;

  ram_byte_t mem [DEPTH];

  // address and data of the single write path
  logic [RAM_ADDR_BITS-1:0] wr_addr;
  ram_byte_t                wr_data;
  logic                     wr_en;
  logic [RAM_ADDR_BITS-1:0] rd_addr;

  // fill byte chosen per instance
  ram_byte_t fill_byte;

  assign fill_byte = use_aram_byte ? fill.aram_byte : fill.wram_byte;

  // clear writes win, core is locked out meanwhile
  always_comb begin
    if (fill.active) begin
      wr_addr = fill.addr[RAM_ADDR_BITS-1:0];
      wr_data = fill_byte;
      wr_en   = 1'b1;
    end else begin
      wr_addr = core_req.addr[RAM_ADDR_BITS-1:0];
      wr_data = core_req.wdata;
      wr_en   = core_req.we;
    end
  end

  assign rd_addr = core_req.addr[RAM_ADDR_BITS-1:0];

  always_ff @(posedge clk_sys) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    // registered read, valid next cycle
    if (core_req.re && !fill.active) begin
      rdata <= mem[rd_addr];
    end
  end

endmodule

// File: include/snes_load_tb_tasks.svh
`ifndef SNES_LOAD_TB_TASKS_SVH
`define SNES_LOAD_TB_TASKS_SVH

// 1 KiB for code 0, doubling per code step, cut to 24 bits
function automatic addr_mask_t expected_mask(mem_size_t code);
  return addr_mask_t'((longint'(1) << (code + 10)) - 1);
endfunction

function automatic ram_byte_t expected_pattern(fill_pattern_e pat, logic [RAM_BITS-1:0] a);
  case (pat)
    PAT_CHECKER: return (a[8] != a[2]) ? 8'h66 : 8'h99;
    PAT_STRIPE:  return (a[9] != a[0]) ? 8'hFF : 8'h00;
    PAT_55:      return 8'h55;
    default:     return 8'hFF;
  endcase
endfunction

// download, then wait for the clear to end and the core to be let go
task automatic run_load(mem_size_t rom, mem_size_t ram, fill_pattern_e wpat,
                        fill_pattern_e apat);
  int n;
  rom_size      = rom;
  ram_size      = ram;
  wram_pattern  = wpat;
  aram_pattern  = apat;
  cart_download = 1'b1;
  repeat (8) next_cycle();
  cart_download = 1'b0;
  compare_value("clear_busy", 32'd1, 32'(clear_busy));
  n = 0;
  while (clear_busy) begin
    // core must stay parked for the whole fill
    compare_value("core_reset_n", 32'd0, 32'(core_reset_n));
    assert (n < DEPTH * CLEAR_DIV_STEPS + 16) else fail_with("clear_busy never fell");
    next_cycle();
    n++;
  end
  n = 0;
  while (!core_reset_n) begin
    assert (n < 16) else fail_with("core_reset_n not released after the clear");
    next_cycle();
    n++;
  end
endtask

// data is back one cycle after the request
task automatic read_byte(logic sel_aram, logic [RAM_BITS-1:0] a, output ram_byte_t data);
  ram_req_t req;
  req      = '0;
  req.addr = ADDR_MAX_BITS'(a);
  req.re   = 1'b1;
  if (sel_aram) aram_req = req;
  else wram_req = req;
  next_cycle();
  wram_req = '0;
  aram_req = '0;
  data = sel_aram ? aram_rdata : wram_rdata;
endtask

task automatic write_byte(logic sel_aram, logic [RAM_BITS-1:0] a, ram_byte_t d);
  ram_req_t req;
  req       = '0;
  req.addr  = ADDR_MAX_BITS'(a);
  req.wdata = d;
  req.we    = 1'b1;
  if (sel_aram) aram_req = req;
  else wram_req = req;
  next_cycle();
  wram_req = '0;
  aram_req = '0;
endtask

task automatic reset_and_refresh();
  logic [15:0] seen;
  compare_value("clear_busy", 32'd0, 32'(clear_busy));
  compare_value("core_reset_n", 32'd0, 32'(core_reset_n));
  for (int i = 0; i < 16; i++) begin
    seen[i] = refresh;
    next_cycle();
  end
  // any four cycles in a row hold one pulse
  for (int i = 0; i < 13; i++) begin
    compare_value("refresh pulses in 4 cycles", 32'd1, 32'($countones(seen[i +: 4])));
  end
endtask

task automatic mask_latch();
  mem_size_t rom;
  mem_size_t ram;
  for (int i = 0; i < 3; i++) begin
    rom = mem_size_t'($urandom % 16);
    // first load without save RAM, later ones always with some
    ram = (i == 0) ? 4'd0 : mem_size_t'($urandom % 15 + 1);
    run_load(rom, ram, PAT_55, PAT_FF);
    compare_value("rom_mask", 32'(expected_mask(rom)), 32'(rom_mask));
    compare_value("ram_mask", (ram == 4'd0) ? 32'd0 : 32'(expected_mask(ram)), 32'(ram_mask));
    compare_value("sram_size", 32'(ram), 32'(sram_size));
  end
endtask

task automatic wram_patterns();
  fill_pattern_e pat;
  ram_byte_t     got;
  for (int p = 0; p < 4; p++) begin
    pat = fill_pattern_e'(p);
    run_load(4'd3, 4'd1, pat, PAT_55);
    for (int i = 0; i < DEPTH; i++) begin
      read_byte(1'b0, RAM_BITS'(i), got);
      compare_value("wram_rdata", 32'(expected_pattern(pat, RAM_BITS'(i))), 32'(got));
    end
  end
endtask

// each RAM keeps the pattern picked for it
task automatic separate_aram_pattern();
  ram_byte_t got;
  run_load(4'd2, 4'd3, PAT_STRIPE, PAT_CHECKER);
  for (int i = 0; i < DEPTH; i++) begin
    read_byte(1'b0, RAM_BITS'(i), got);
    compare_value("wram_rdata", 32'(expected_pattern(PAT_STRIPE, RAM_BITS'(i))), 32'(got));
    read_byte(1'b1, RAM_BITS'(i), got);
    compare_value("aram_rdata", 32'(expected_pattern(PAT_CHECKER, RAM_BITS'(i))), 32'(got));
  end
endtask

task automatic core_access();
  logic [RAM_BITS-1:0] a;
  ram_byte_t           wd;
  ram_byte_t           got;
  run_load(4'd5, 4'd2, PAT_FF, PAT_55);
  for (int i = 0; i < 16; i++) begin
    a  = RAM_BITS'($urandom);
    wd = ram_byte_t'($urandom);
    write_byte(1'b0, a, wd);
    read_byte(1'b0, a, got);
    compare_value("wram_rdata", 32'(wd), 32'(got));
    a  = RAM_BITS'($urandom);
    wd = ram_byte_t'($urandom);
    write_byte(1'b1, a, wd);
    read_byte(1'b1, a, got);
    compare_value("aram_rdata", 32'(wd), 32'(got));
  end
endtask

task automatic external_core_reset();
  int n;
  compare_value("core_reset_n", 32'd1, 32'(core_reset_n));
  core_reset = 1'b1;
  // reset moves only once per divider turn
  repeat (4) next_cycle();
  for (int i = 0; i < 12; i++) begin
    compare_value("core_reset_n", 32'd0, 32'(core_reset_n));
    next_cycle();
  end
  core_reset = 1'b0;
  n = 0;
  while (!core_reset_n) begin
    assert (n < 4) else fail_with("core_reset_n not back within four cycles");
    next_cycle();
    n++;
  end
endtask

`endif

// File: verif/snes_load_tb.sv
module snes_load_tb
  import snes_load_pkg::*;
();

  localparam int RAM_BITS = 10;
  localparam int DEPTH = 1 << RAM_BITS;
  localparam int CLK_PERIOD = 100;
  localparam int DRIVE_DLY = 10;
  // 3 mask loads, 4 pattern loads, 1 audio RAM load, 1 core access load
  localparam int NUM_LOADS = 9;
  // full clear, then one readback pass over both RAMs
  localparam longint LOAD_CYCLES = DEPTH * CLEAR_DIV_STEPS + 2 * DEPTH + 200;
  localparam longint WATCHDOG_TIME = (NUM_LOADS * LOAD_CYCLES + 1000) * CLK_PERIOD;

  logic          clk_sys;
  logic          reset;
  logic          core_reset;
  logic          cart_download;
  mem_size_t     rom_size;
  mem_size_t     ram_size;
  fill_pattern_e wram_pattern;
  fill_pattern_e aram_pattern;
  ram_req_t      wram_req;
  ram_req_t      aram_req;
  ram_byte_t     wram_rdata;
  ram_byte_t     aram_rdata;
  addr_mask_t    rom_mask;
  addr_mask_t    ram_mask;
  mem_size_t     sram_size;
  logic          clear_busy;
  logic          core_reset_n;
  logic          refresh;

  always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

  snes_load_top #(
    .RAM_ADDR_BITS (RAM_BITS)
  ) UUT (.*);

  // inputs change and outputs are sampled just after the rising edge
  task automatic next_cycle();
    @(posedge clk_sys);
    #(DRIVE_DLY);
  endtask

  task automatic stop_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped on the first failure");
  endtask

  task automatic fail_with(string what);
    $display("%s, at time %0t", what, $time);
    stop_run();
  endtask

  task automatic compare_value(string name, logic [31:0] exp, logic [31:0] act);
    assert (act === exp) else begin
      $display("Error at time %0t: %s expected 0x%0h, actual 0x%0h",
               $time, name, exp, act);
      stop_run();
    end
  endtask

  `include "snes_load_tb_tasks.svh"

  initial begin
    void'($urandom(32'hd8d3a468));
    clk_sys       = 1'b0;
    reset         = 1'b0;
    core_reset    = 1'b0;
    cart_download = 1'b0;
    rom_size      = '0;
    ram_size      = '0;
    wram_pattern  = PAT_CHECKER;
    aram_pattern  = PAT_CHECKER;
    wram_req      = '0;
    aram_req      = '0;
    // two edges with reset held low
    repeat (2) @(posedge clk_sys);
    #(DRIVE_DLY);
    reset = 1'b1;
    reset_and_refresh();
    mask_latch();
    wram_patterns();
    separate_aram_pattern();
    core_access();
    external_core_reset();
    $display("ALL TESTS PASSED");
    $finish;
  end

  // every load bounded by a full clear plus readback
  initial begin
    #(WATCHDOG_TIME);
    $display("timeout, tests still running after %0d time units", WATCHDOG_TIME);
    stop_run();
  end

endmodule

// File: vlog.f
+incdir+include
design/snes_load_pkg.sv
design/load_sequencer.sv
design/ram_clear_engine.sv
design/work_ram.sv
design/core_reset_gen.sv
design/snes_load_top.sv
verif/snes_load_tb.sv
